/* Makefile */
# Verilator build and run for the out-of-order back end

VERILATOR ?= verilator
TOP       ?= tb_ooo_core
RTL_TOP   ?= ooo_core
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation finished: PASS

RTL_SRCS  ?= $(filter src/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the log
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
src/core_pkg.sv
src/dispatch_rename.sv
src/phys_reg_file.sv
src/issue_table.sv
src/exec_units.sv
src/reorder_buffer.sv
src/ooo_core.sv
testbench/tb_ooo_core.sv

/* src/core_pkg.sv */
package core_pkg;

    // Datapath and register widths
    localparam int XLEN      = 32;
    localparam int ARCH_REGS = 32;
    localparam int AREG_W    = 5;
    localparam int PHYS_REGS = 48;
    localparam int PREG_W    = 6;

    // Queue sizes and latencies
    localparam int ROB_DEPTH  = 8;
    localparam int ROB_ID_W   = 3;
    localparam int IQ_DEPTH   = 4;
    localparam int IQ_ID_W    = 2;
    localparam int MUL_STAGES = 3;
    localparam int IMM_W      = 12;

    // Lane 0 carries the ALU, lane 1 the multiplier
    localparam int CDB_LANES = 2;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_ADDI = 3'd5,
        OP_MUL  = 3'd6
    } op_e;

    typedef struct packed {
        op_e               op;
        logic [AREG_W-1:0] rd;
        logic [AREG_W-1:0] rs1;
        logic [AREG_W-1:0] rs2;
        logic [IMM_W-1:0]  imm;
    } dec_inst_t;

    typedef struct packed {
        logic                valid;
        op_e                 op;
        logic [AREG_W-1:0]   rd;
        logic [PREG_W-1:0]   prd;
        logic [PREG_W-1:0]   old_prd;
        logic [PREG_W-1:0]   prs1;
        logic [PREG_W-1:0]   prs2;
        logic [IMM_W-1:0]    imm;
        logic [ROB_ID_W-1:0] rob_id;
    } dispatch_t;

    typedef struct packed {
        logic                valid;
        op_e                 op;
        logic [XLEN-1:0]     a;
        logic [XLEN-1:0]     b;
        logic [PREG_W-1:0]   prd;
        logic [ROB_ID_W-1:0] rob_id;
    } fu_req_t;

    typedef struct packed {
        logic                valid;
        logic [PREG_W-1:0]   preg;
        logic [ROB_ID_W-1:0] rob_id;
        logic [XLEN-1:0]     value;
    } cdb_t;

    typedef struct packed {
        logic              valid;
        logic [PREG_W-1:0] preg;
    } retire_t;

    typedef struct packed {
        logic [AREG_W-1:0] rd;
        logic [XLEN-1:0]   value;
    } commit_t;

endpackage

/* src/dispatch_rename.sv */
`timescale 1ns/100ps

module dispatch_rename (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          inst_req,
    input  core_pkg::dec_inst_t           inst,
    output logic                          inst_ack,
    input  logic [core_pkg::ROB_ID_W-1:0] rob_tail,
    input  logic                          rob_full,
    input  logic                          iq_full,
    input  core_pkg::retire_t             retire,
    output core_pkg::dispatch_t           dispatch
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_ACK
    } intake_e;

    intake_e              state;
    logic [PREG_W-1:0]    rat [ARCH_REGS];
    logic [PHYS_REGS-1:0] free_map;
    logic [PREG_W-1:0]    new_preg;
    logic                 have_free;
    logic                 need_reg;
    logic                 fire;

    // Lowest-numbered free register wins
    always_comb begin
        new_preg  = '0;
        have_free = 1'b0;
        for (int i = PHYS_REGS - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                new_preg  = PREG_W'(i);
                have_free = 1'b1;
            end
        end
    end

    // x0 never gets a new mapping
    assign need_reg = (inst.rd != '0);
    assign fire     = (state == S_WAIT) && !rob_full && !iq_full && (have_free || !need_reg);
    assign inst_ack = (state == S_ACK) || fire;

    always_comb begin
        dispatch.valid   = fire;
        dispatch.op      = inst.op;
        dispatch.rd      = inst.rd;
        dispatch.prd     = need_reg ? new_preg : '0;
        dispatch.old_prd = rat[inst.rd];
        dispatch.prs1    = rat[inst.rs1];
        // ADDI has no second source; physical 0 is always ready
        dispatch.prs2    = (inst.op == OP_ADDI) ? '0 : rat[inst.rs2];
        dispatch.imm     = inst.imm;
        dispatch.rob_id  = rob_tail;
    end

    // Four-phase intake
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (inst_req) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (fire) begin
                        state <= S_ACK;
                    end
                end
                S_ACK: begin
                    if (!inst_req) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Alias table and free bitmap
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                rat[i] <= PREG_W'(i);
            end
            free_map <= {{(PHYS_REGS - ARCH_REGS){1'b1}}, {ARCH_REGS{1'b0}}};
        end else begin
            if (fire && need_reg) begin
                rat[inst.rd]       <= new_preg;
                free_map[new_preg] <= 1'b0;
            end
            if (retire.valid) begin
                free_map[retire.preg] <= 1'b1;
            end
        end
    end

endmodule

/* src/exec_units.sv */
`timescale 1ns/100ps

module exec_units (
    input  logic                                     clk,
    input  logic                                     rst,
    input  core_pkg::fu_req_t                        alu_req,
    input  core_pkg::fu_req_t                        mul_req,
    output core_pkg::cdb_t [core_pkg::CDB_LANES-1:0] cdb
);
    import core_pkg::*;

    cdb_t            alu_q;
    cdb_t            mul_pipe [MUL_STAGES];
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] imm_ext;
    logic [XLEN-1:0] mul_lo;

    assign imm_ext = {{(XLEN - IMM_W){alu_req.b[IMM_W-1]}}, alu_req.b[IMM_W-1:0]};

    always_comb begin
        case (alu_req.op)
            OP_ADD:  alu_result = alu_req.a + alu_req.b;
            OP_SUB:  alu_result = alu_req.a - alu_req.b;
            OP_AND:  alu_result = alu_req.a & alu_req.b;
            OP_OR:   alu_result = alu_req.a | alu_req.b;
            OP_XOR:  alu_result = alu_req.a ^ alu_req.b;
            OP_ADDI: alu_result = alu_req.a + imm_ext;
            default: alu_result = '0;
        endcase
    end

    // Single-cycle ALU onto lane 0
    always_ff @(posedge clk) begin
        alu_q.preg   <= alu_req.prd;
        alu_q.rob_id <= alu_req.rob_id;
        alu_q.value  <= alu_result;
        if (rst) begin
            alu_q.valid <= 1'b0;
        end else begin
            alu_q.valid <= alu_req.valid;
        end
    end

    // Low half of the product only
    assign mul_lo = mul_req.a * mul_req.b;

    // Product and tag travel down the stages together
    always_ff @(posedge clk) begin
        mul_pipe[0].preg   <= mul_req.prd;
        mul_pipe[0].rob_id <= mul_req.rob_id;
        mul_pipe[0].value  <= mul_lo;
        for (int s = 1; s < MUL_STAGES; s++) begin
            mul_pipe[s] <= mul_pipe[s-1];
        end
        if (rst) begin
            for (int s = 0; s < MUL_STAGES; s++) begin
                mul_pipe[s].valid <= 1'b0;
            end
        end else begin
            mul_pipe[0].valid <= mul_req.valid;
        end
    end

    assign cdb[0] = alu_q;
    assign cdb[1] = mul_pipe[MUL_STAGES-1];

endmodule

/* src/issue_table.sv */
`timescale 1ns/100ps

module issue_table (
    input  logic                                     clk,
    input  logic                                     rst,
    input  core_pkg::dispatch_t                      dispatch,
    input  logic [1:0]                               src_ready,
    input  core_pkg::cdb_t [core_pkg::CDB_LANES-1:0] cdb,
    output logic                                     iq_full,
    output logic [1:0][core_pkg::PREG_W-1:0]         src_addr,
    input  logic [1:0][core_pkg::XLEN-1:0]           src_data,
    output core_pkg::fu_req_t                        alu_req,
    output core_pkg::fu_req_t                        mul_req
);
    import core_pkg::*;

    typedef struct packed {
        logic                valid;
        op_e                 op;
        logic [PREG_W-1:0]   prs1;
        logic                rdy1;
        logic [PREG_W-1:0]   prs2;
        logic                rdy2;
        logic [PREG_W-1:0]   prd;
        logic [ROB_ID_W-1:0] rob_id;
        logic [IMM_W-1:0]    imm;
    } iq_entry_t;

    iq_entry_t          entries [IQ_DEPTH];
    iq_entry_t          sel;
    fu_req_t            req;
    logic [IQ_ID_W-1:0] issue_idx;
    logic [IQ_ID_W-1:0] free_idx;
    logic               issue_ok;

    // Lowest ready entry issues, lowest empty slot takes the next dispatch
    always_comb begin
        issue_idx = '0;
        issue_ok  = 1'b0;
        free_idx  = '0;
        iq_full   = 1'b1;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (entries[i].valid && entries[i].rdy1 && entries[i].rdy2) begin
                issue_idx = IQ_ID_W'(i);
                issue_ok  = 1'b1;
            end
            if (!entries[i].valid) begin
                free_idx = IQ_ID_W'(i);
                iq_full  = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            // CDB wakeup
            for (int i = 0; i < IQ_DEPTH; i++) begin
                for (int l = 0; l < CDB_LANES; l++) begin
                    if (cdb[l].valid && cdb[l].preg == entries[i].prs1) begin
                        entries[i].rdy1 <= 1'b1;
                    end
                    if (cdb[l].valid && cdb[l].preg == entries[i].prs2) begin
                        entries[i].rdy2 <= 1'b1;
                    end
                end
            end
            if (issue_ok) begin
                entries[issue_idx].valid <= 1'b0;
            end
            if (dispatch.valid) begin
                entries[free_idx].valid  <= 1'b1;
                entries[free_idx].op     <= dispatch.op;
                entries[free_idx].prs1   <= dispatch.prs1;
                entries[free_idx].rdy1   <= src_ready[0];
                entries[free_idx].prs2   <= dispatch.prs2;
                entries[free_idx].rdy2   <= src_ready[1];
                entries[free_idx].prd    <= dispatch.prd;
                entries[free_idx].rob_id <= dispatch.rob_id;
                entries[free_idx].imm    <= dispatch.imm;
            end
        end
    end

    always_comb begin
        sel         = entries[issue_idx];
        src_addr[0] = sel.prs1;
        src_addr[1] = sel.prs2;
        req.valid   = issue_ok;
        req.op      = sel.op;
        req.a       = src_data[0];
        // Raw immediate rides in operand b and is sign-extended in the ALU
        req.b       = (sel.op == OP_ADDI) ? XLEN'(sel.imm) : src_data[1];
        req.prd     = sel.prd;
        req.rob_id  = sel.rob_id;

        alu_req       = req;
        alu_req.valid = issue_ok && (sel.op != OP_MUL);
        mul_req       = req;
        mul_req.valid = issue_ok && (sel.op == OP_MUL);
    end

endmodule

/* src/ooo_core.sv */
`timescale 1ns/100ps

module ooo_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_req,
    input  core_pkg::dec_inst_t inst,
    output logic                inst_ack,
    output logic                commit_req,
    output core_pkg::commit_t   commit,
    input  logic                commit_ack
);
    import core_pkg::*;

    dispatch_t                dispatch;
    cdb_t [CDB_LANES-1:0]     cdb;
    retire_t                  retire;
    fu_req_t                  alu_req;
    fu_req_t                  mul_req;
    logic [ROB_ID_W-1:0]      rob_tail;
    logic                     rob_full;
    logic                     iq_full;
    logic [1:0][PREG_W-1:0]   src_addr;
    logic [1:0][XLEN-1:0]     src_data;
    logic [1:0]               src_ready;

    dispatch_rename u_rename (
        .clk(clk), .rst(rst),
        .inst_req(inst_req), .inst(inst), .inst_ack(inst_ack),
        .rob_tail(rob_tail), .rob_full(rob_full), .iq_full(iq_full),
        .retire(retire), .dispatch(dispatch)
    );

    phys_reg_file u_prf (
        .clk(clk), .rst(rst), .dispatch(dispatch), .cdb(cdb),
        .src_addr(src_addr), .src_data(src_data), .src_ready(src_ready)
    );

    issue_table u_iq (
        .clk(clk), .rst(rst), .dispatch(dispatch), .src_ready(src_ready),
        .cdb(cdb), .iq_full(iq_full), .src_addr(src_addr), .src_data(src_data),
        .alu_req(alu_req), .mul_req(mul_req)
    );

    exec_units u_exec (
        .clk(clk), .rst(rst), .alu_req(alu_req), .mul_req(mul_req), .cdb(cdb)
    );

    reorder_buffer u_rob (
        .clk(clk), .rst(rst), .dispatch(dispatch), .cdb(cdb),
        .rob_tail(rob_tail), .rob_full(rob_full), .retire(retire),
        .commit_req(commit_req), .commit(commit), .commit_ack(commit_ack)
    );

endmodule

/* src/phys_reg_file.sv */
`timescale 1ns/100ps

module phys_reg_file (
    input  logic                                          clk,
    input  logic                                          rst,
    input  core_pkg::dispatch_t                           dispatch,
    input  core_pkg::cdb_t [core_pkg::CDB_LANES-1:0]      cdb,
    input  logic [1:0][core_pkg::PREG_W-1:0]              src_addr,
    output logic [1:0][core_pkg::XLEN-1:0]                src_data,
    output logic [1:0]                                    src_ready
);
    import core_pkg::*;

    logic [XLEN-1:0]           regs [PHYS_REGS];
    logic [PHYS_REGS-1:0]      ready;
    logic [1:0][PREG_W-1:0]    disp_src;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
            ready <= '1;
        end else begin
            // New destination waits for its producer
            if (dispatch.valid && dispatch.rd != '0) begin
                ready[dispatch.prd] <= 1'b0;
            end
            // Physical 0 backs x0 and is never written
            for (int l = 0; l < CDB_LANES; l++) begin
                if (cdb[l].valid && cdb[l].preg != '0) begin
                    regs[cdb[l].preg]  <= cdb[l].value;
                    ready[cdb[l].preg] <= 1'b1;
                end
            end
        end
    end

    assign src_data[0] = regs[src_addr[0]];
    assign src_data[1] = regs[src_addr[1]];

    assign disp_src[0] = dispatch.prs1;
    assign disp_src[1] = dispatch.prs2;

    // Readiness for the dispatching instruction, bypassing same-cycle CDB writes
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_ready[s] = ready[disp_src[s]];
            for (int l = 0; l < CDB_LANES; l++) begin
                if (cdb[l].valid && cdb[l].preg == disp_src[s]) begin
                    src_ready[s] = 1'b1;
                end
            end
        end
    end

endmodule

/* src/reorder_buffer.sv */
`timescale 1ns/100ps

module reorder_buffer (
    input  logic                                     clk,
    input  logic                                     rst,
    input  core_pkg::dispatch_t                      dispatch,
    input  core_pkg::cdb_t [core_pkg::CDB_LANES-1:0] cdb,
    output logic [core_pkg::ROB_ID_W-1:0]            rob_tail,
    output logic                                     rob_full,
    output core_pkg::retire_t                        retire,
    output logic                                     commit_req,
    output core_pkg::commit_t                        commit,
    input  logic                                     commit_ack
);
    import core_pkg::*;

    logic [AREG_W-1:0]    rd_mem [ROB_DEPTH];
    logic [PREG_W-1:0]    old_mem [ROB_DEPTH];
    logic [XLEN-1:0]      value_mem [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done;
    logic [ROB_ID_W-1:0]  head;
    logic [ROB_ID_W-1:0]  tail;
    logic [ROB_ID_W:0]    count;
    logic                 req_q;
    logic                 pop;
    logic                 head_ready;

    assign rob_tail   = tail;
    assign rob_full   = (count == (ROB_ID_W + 1)'(ROB_DEPTH));
    assign head_ready = (count != '0) && done[head];

    assign commit_req   = req_q;
    assign pop          = req_q && commit_ack;
    assign commit.rd    = rd_mem[head];
    // x0 always retires as zero
    assign commit.value = (rd_mem[head] == '0) ? '0 : value_mem[head];

    assign retire.valid = pop && (rd_mem[head] != '0);
    assign retire.preg  = old_mem[head];

    // Entry payload
    always_ff @(posedge clk) begin
        if (dispatch.valid) begin
            rd_mem[tail]  <= dispatch.rd;
            old_mem[tail] <= dispatch.old_prd;
        end
        for (int l = 0; l < CDB_LANES; l++) begin
            if (cdb[l].valid) begin
                value_mem[cdb[l].rob_id] <= cdb[l].value;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
            req_q <= 1'b0;
        end else begin
            if (dispatch.valid) begin
                tail       <= tail + 1'b1;
                done[tail] <= 1'b0;
            end
            for (int l = 0; l < CDB_LANES; l++) begin
                if (cdb[l].valid) begin
                    done[cdb[l].rob_id] <= 1'b1;
                end
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            count <= count + {{ROB_ID_W{1'b0}}, dispatch.valid} - {{ROB_ID_W{1'b0}}, pop};

            // New commit request only after ack has dropped
            if (pop) begin
                req_q <= 1'b0;
            end else if (!req_q && head_ready && !commit_ack) begin
                req_q <= 1'b1;
            end
        end
    end

endmodule

/* testbench/tb_ooo_core.sv */
`timescale 1ns/100ps

module tb_ooo_core;
    import core_pkg::*;

    localparam int NUM_TESTS      = 6;
    localparam int T5_LEN         = 72;
    localparam int T6_LEN         = 24;
    localparam int TABLE_LEN      = 1 + 7 + 7 + 9 + T5_LEN + T6_LEN;
    localparam int TIMEOUT_CYCLES = 40 * TABLE_LEN + 100;

    // One table row holds the instruction and the value its destination must commit
    typedef struct packed {
        dec_inst_t       inst;
        logic [XLEN-1:0] exp_value;
    } vector_t;

    logic      clk;
    logic      rst;
    logic      inst_req;
    dec_inst_t inst;
    logic      inst_ack;
    logic      commit_req;
    commit_t   commit;
    logic      commit_ack;

    vector_t vectors [TABLE_LEN];
    int      test_first [NUM_TESTS + 1];
    string   test_name [NUM_TESTS];
    int      n_vec;
    int      errors;
    int      checks;
    int      passed;
    int      failed;
    int      cycles;
    integer  seed = 98;

    ooo_core DUT (
        .clk(clk), .rst(rst),
        .inst_req(inst_req), .inst(inst), .inst_ack(inst_ack),
        .commit_req(commit_req), .commit(commit), .commit_ack(commit_ack)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic add_inst(input op_e op, input logic [AREG_W-1:0] rd,
                            input logic [AREG_W-1:0] rs1, input logic [AREG_W-1:0] rs2,
                            input logic [IMM_W-1:0] imm);
        vectors[n_vec].inst.op   = op;
        vectors[n_vec].inst.rd   = rd;
        vectors[n_vec].inst.rs1  = rs1;
        vectors[n_vec].inst.rs2  = rs2;
        vectors[n_vec].inst.imm  = imm;
        vectors[n_vec].exp_value = '0;
        n_vec++;
    endtask

    task automatic build_program;
        logic [AREG_W-1:0] rd;
        logic [AREG_W-1:0] rs1;
        logic [AREG_W-1:0] rs2;
        op_e               op;
        int                r;
        n_vec = 0;
        test_first[0] = 0;
        test_name[0]  = "reset and first ADDI";
        add_inst(OP_ADDI, 5'd1, 5'd0, 5'd0, 12'hffb);
        test_first[1] = n_vec;
        test_name[1]  = "independent ALU ops";
        add_inst(OP_ADDI, 5'd2, 5'd0, 5'd0, 12'h123);
        add_inst(OP_ADDI, 5'd3, 5'd0, 5'd0, 12'h7ff);
        add_inst(OP_ADD, 5'd4, 5'd2, 5'd3, 12'h000);
        add_inst(OP_SUB, 5'd5, 5'd2, 5'd3, 12'h000);
        add_inst(OP_AND, 5'd6, 5'd2, 5'd3, 12'h000);
        add_inst(OP_OR, 5'd7, 5'd2, 5'd3, 12'h000);
        add_inst(OP_XOR, 5'd8, 5'd2, 5'd3, 12'h000);
        test_first[2] = n_vec;
        test_name[2]  = "dependent chains";
        add_inst(OP_ADDI, 5'd9, 5'd1, 5'd0, 12'h003);
        add_inst(OP_ADD, 5'd9, 5'd9, 5'd9, 12'h000);
        add_inst(OP_SUB, 5'd10, 5'd9, 5'd1, 12'h000);
        add_inst(OP_XOR, 5'd9, 5'd10, 5'd9, 12'h000);
        add_inst(OP_ADDI, 5'd9, 5'd9, 5'd0, 12'hfff);
        add_inst(OP_MUL, 5'd11, 5'd9, 5'd9, 12'h000);
        add_inst(OP_ADD, 5'd12, 5'd11, 5'd9, 12'h000);
        test_first[3] = n_vec;
        test_name[3]  = "MUL ordering";
        // Dependent MULs hold back x14 so the ADDs after it complete first
        add_inst(OP_MUL, 5'd13, 5'd3, 5'd2, 12'h000);
        add_inst(OP_MUL, 5'd13, 5'd13, 5'd3, 12'h000);
        add_inst(OP_MUL, 5'd13, 5'd13, 5'd2, 12'h000);
        add_inst(OP_MUL, 5'd14, 5'd13, 5'd3, 12'h000);
        add_inst(OP_ADD, 5'd15, 5'd2, 5'd2, 12'h000);
        add_inst(OP_ADD, 5'd16, 5'd3, 5'd3, 12'h000);
        add_inst(OP_ADDI, 5'd17, 5'd0, 5'd0, 12'h001);
        add_inst(OP_MUL, 5'd18, 5'd14, 5'd3, 12'h000);
        add_inst(OP_ADD, 5'd19, 5'd18, 5'd17, 12'h000);
        test_first[4] = n_vec;
        test_name[4]  = "register recycling";
        // Every eighth write goes to x0
        for (int i = 0; i < T5_LEN; i++) begin
            rd  = (i % 8 == 7) ? 5'd0 : 5'(20 + i % 8);
            rs1 = 5'(20 + (i + 1) % 8);
            rs2 = 5'(20 + (i + 5) % 8);
            case (i % 4)
                0:       add_inst(OP_ADDI, rd, rs1, 5'd0, 12'(i * 37 + 1));
                1:       add_inst(OP_ADD, rd, rs1, rs2, 12'h000);
                2:       add_inst(OP_MUL, rd, rs1, rs2, 12'h000);
                default: add_inst(OP_SUB, rd, rs1, rs2, 12'h000);
            endcase
        end
        test_first[5] = n_vec;
        test_name[5]  = "random commit back-pressure";
        // ADDI gets a random rs2 too, which it must ignore
        for (int i = 0; i < T6_LEN; i++) begin
            r   = $random(seed);
            op  = op_e'(3'((r & 32'h7fff_ffff) % 7));
            rd  = 5'($random(seed));
            rs1 = 5'($random(seed));
            rs2 = 5'($random(seed));
            add_inst(op, rd, rs1, rs2, 12'($random(seed)));
        end
        test_first[6] = n_vec;
    endtask

    // Architectural model, executed in program order
    task automatic compute_expected;
        logic [XLEN-1:0]        arch [ARCH_REGS];
        logic [XLEN-1:0]        a;
        logic [XLEN-1:0]        b;
        logic [XLEN-1:0]        result;
        logic signed [XLEN-1:0] imm_s;
        dec_inst_t              d;
        for (int i = 0; i < ARCH_REGS; i++) begin
            arch[i] = '0;
        end
        for (int k = 0; k < TABLE_LEN; k++) begin
            d     = vectors[k].inst;
            a     = arch[d.rs1];
            b     = arch[d.rs2];
            imm_s = $signed(d.imm);
            case (d.op)
                OP_ADD:  result = a + b;
                OP_SUB:  result = a - b;
                OP_AND:  result = a & b;
                OP_OR:   result = a | b;
                OP_XOR:  result = a ^ b;
                OP_ADDI: result = a + imm_s;
                OP_MUL:  result = a * b;
                default: result = '0;
            endcase
            if (d.rd != '0) begin
                arch[d.rd] = result;
            end
            vectors[k].exp_value = (d.rd == '0) ? '0 : result;
        end
    endtask

    // Send one instruction through the four-phase intake
    task automatic send_inst(input dec_inst_t d);
        inst     = d;
        inst_req = 1'b1;
        @(negedge clk);
        while (!inst_ack) @(negedge clk);
        inst_req = 1'b0;
        @(negedge clk);
        while (inst_ack) @(negedge clk);
    endtask

    task automatic accept_commits(input int first, input int last, input bit random_ack);
        int delay;
        for (int k = first; k <= last; k++) begin
            while (!commit_req) @(negedge clk);
            if (random_ack) begin
                delay = int'($random(seed) & 32'h7);
                repeat (delay) @(negedge clk);
            end
            checks++;
            assert (commit.rd == vectors[k].inst.rd) else begin
                $display("Error: commit.rd at entry %0d expected 0x%02h got 0x%02h",
                         k, vectors[k].inst.rd, commit.rd);
                errors++;
            end
            assert (commit.value == vectors[k].exp_value) else begin
                $display("Error: commit.value at entry %0d expected 0x%08h got 0x%08h",
                         k, vectors[k].exp_value, commit.value);
                errors++;
            end
            commit_ack = 1'b1;
            @(negedge clk);
            while (commit_req) @(negedge clk);
            commit_ack = 1'b0;
        end
    endtask

    task automatic run_test(input int t);
        int first;
        int last;
        int errors_before;
        first         = test_first[t];
        last          = test_first[t + 1] - 1;
        errors_before = errors;
        if (t == 0) begin
            assert (!inst_ack) else begin
                $display("Error: inst_ack after reset expected 0x0 got 0x%0h", inst_ack);
                errors++;
            end
            assert (!commit_req) else begin
                $display("Error: commit_req after reset expected 0x0 got 0x%0h", commit_req);
                errors++;
            end
        end
        fork
            begin
                for (int k = first; k <= last; k++) begin
                    send_inst(vectors[k].inst);
                end
            end
            accept_commits(first, last, t == NUM_TESTS - 1);
        join
        // Nothing may be left to commit once the test's entries are done
        repeat (4) @(negedge clk);
        assert (!commit_req) else begin
            $display("Extra commit request after test %0d, an instruction was duplicated",
                     t + 1);
            errors++;
        end
        if (errors == errors_before) begin
            passed++;
            $display("Test %0d %s: passed", t + 1, test_name[t]);
        end else begin
            failed++;
            $display("Test %0d %s: failed with %0d errors", t + 1, test_name[t],
                     errors - errors_before);
        end
    endtask

    initial begin
        rst        = 1'b1;
        inst_req   = 1'b0;
        inst       = '0;
        commit_ack = 1'b0;
        errors     = 0;
        checks     = 0;
        passed     = 0;
        failed     = 0;
        build_program();
        compute_expected();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
                 passed, failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Cycle limit scaled by the table length
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, commits stopped arriving", cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
